//--- hdl/sys_bus_consts.svh
//////////////////////////////
// widths, timeout and register map shared by the axi bridge and its bus slave
// include wherever one of these numbers is needed
//////////////////////////////
`ifndef SYS_BUS_CONSTS_SVH
`define SYS_BUS_CONSTS_SVH

// axi channel widths
`define AXI_DW 32           // data
`define AXI_AW 32           // address
`define AXI_IW 8            // transaction id

// bridge gives up on a missing ack after this many cycles
`define ACK_TIMEOUT 32

// register bank map, 4-byte steps from the base
`define REG_COUNT 8
`define REG_BASE 32'h4000_0000

`endif

//--- hdl/sys_bus_pkg.sv
//////////////////////////////
// axi channel beats, system bus command/answer and response codes
// imported by every block that touches the bridge
//////////////////////////////
`include "sys_bus_consts.svh"

package sys_bus_pkg;

   //////////////////////////////
   // axi channels
   //////////////////////////////

   // one address beat, same layout for aw and ar
   typedef struct packed {
      logic [`AXI_IW-1:0] id;
      logic [`AXI_AW-1:0] addr;
      logic [7:0]         len;    // beats - 1, only 0 supported
      logic [2:0]         size;   // log2 bytes per beat
   } axi_addr_t;

   typedef axi_addr_t axi_aw_t;   // write address
   typedef axi_addr_t axi_ar_t;   // read address

   typedef struct packed {
      logic [`AXI_DW-1:0] data;
      logic               last;
   } axi_w_t;

   typedef struct packed {
      logic [`AXI_IW-1:0] id;
      logic [1:0]         resp;
   } axi_b_t;

   typedef struct packed {
      logic [`AXI_IW-1:0] id;
      logic [`AXI_DW-1:0] data;
      logic [1:0]         resp;
      logic               last;
   } axi_r_t;

   //////////////////////////////
   // system bus
   //////////////////////////////

   typedef struct packed {
      logic [`AXI_AW-1:0] addr;
      logic [`AXI_DW-1:0] wdata;
      logic               wen;    // single cycle pulse
      logic               ren;    // single cycle pulse
   } sys_req_t;

   typedef struct packed {
      logic [`AXI_DW-1:0] rdata;
      logic               ack;    // one cycle, only for mapped addresses
   } sys_rsp_t;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- hdl/axi_req_hold.sv
`timescale 1ns/1ns
//////////////////////////////
// captures one accepted address beat and keeps it until the access is done
//////////////////////////////

module axi_req_hold #(
   parameter type payload_t = logic
) (
   input  logic     axi,
   input  logic     rst_n,
   // axi address channel
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   // from the bridge
   input  logic     accept_ok,  // arbiter permit
   input  logic     done,       // response handed over
   // to the bridge
   output logic     held,
   output payload_t held_data
);

   logic take;

   // only one request in flight per holder
   assign in_ready = accept_ok & ~held;
   assign take     = in_valid & in_ready;

   // busy flag
   always_ff @(posedge axi) begin
      if (!rst_n) begin
         held <= 1'b0;
      end else if (take) begin
         held <= 1'b1;
      end else if (done) begin
         held <= 1'b0;   // free again next cycle
      end
   end

   // payload, only loaded on a transfer
   always_ff @(posedge axi) begin
      if (take) begin
         held_data <= in_data;
      end
   end

endmodule

//--- hdl/axi_sys_bridge.sv
`timescale 1ns/1ns
//////////////////////////////
// single access axi to system bus engine, write before read, with request
// check and ack timeout; builds the b and r beats from the held request
//////////////////////////////
`include "sys_bus_consts.svh"

module axi_sys_bridge (
   input  logic                  axi,
   input  logic                  rst_n,
   // holding stages
   input  logic                  aw_held,
   input  sys_bus_pkg::axi_aw_t  aw_req,
   input  logic                  ar_held,
   input  sys_bus_pkg::axi_ar_t  ar_req,
   output logic                  aw_ok,
   output logic                  ar_ok,
   output logic                  aw_done,
   output logic                  ar_done,
   // axi channels
   input  logic                  aw_valid,
   input  logic                  w_valid,
   output logic                  w_ready,
   input  sys_bus_pkg::axi_w_t   w,
   output logic                  b_valid,
   input  logic                  b_ready,
   output sys_bus_pkg::axi_b_t   b,
   output logic                  r_valid,
   input  logic                  r_ready,
   output sys_bus_pkg::axi_r_t   r,
   // system bus
   output sys_bus_pkg::sys_req_t bus_req,
   input  sys_bus_pkg::sys_rsp_t bus_rsp
);
   import sys_bus_pkg::*;

   axi_addr_t          cur;        // request being served
   logic               busy;
   logic               err;        // unsupported len/size
   logic               w_got;      // write data taken
   logic [`AXI_DW-1:0] wdata_q;
   logic               issued;     // strobe slot used
   logic               issue_now;
   logic               wen_q;
   logic               ren_q;
   logic               err_ack;    // stands in for ack on rejected requests
   logic [5:0]         cnt;        // cycles since acceptance
   logic               tmo;
   logic               resp_out;
   logic               rsp_due;
   logic               fail;

   //////////////////////////////
   // arbitration
   //////////////////////////////

   assign busy  = aw_held | ar_held;
   assign aw_ok = ~busy;
   assign ar_ok = ~busy & ~aw_valid;   // pending write goes first

   assign cur = aw_held ? aw_req : ar_req;

   // single beat of 2 or 4 bytes only
   assign err = (cur.len != 8'd0) || !((cur.size == 3'd1) || (cur.size == 3'd2));

   //////////////////////////////
   // write data
   //////////////////////////////

   // write busy: ready follows valid until the one beat is in
   assign w_ready = aw_held & ~w_got & w_valid;

   always_ff @(posedge axi) begin
      if (!rst_n) begin
         w_got <= 1'b0;
      end else if (aw_done) begin
         w_got <= 1'b0;
      end else if (w_valid && w_ready) begin
         w_got <= 1'b1;
      end
   end

   always_ff @(posedge axi) begin
      if (w_valid && w_ready) begin
         wdata_q <= w.data;
      end
   end

   //////////////////////////////
   // strobe and timeout
   //////////////////////////////

   assign resp_out  = b_valid | r_valid;
   assign issue_now = ~issued & ~resp_out & (ar_held | (aw_held & w_got));

   always_ff @(posedge axi) begin
      if (!rst_n) begin
         issued  <= 1'b0;
         wen_q   <= 1'b0;
         ren_q   <= 1'b0;
         err_ack <= 1'b0;
      end else begin
         if (aw_done || ar_done) begin
            issued <= 1'b0;
         end else if (issue_now) begin
            issued <= 1'b1;
         end
         wen_q   <= issue_now & aw_held & ~err;   // pulses, never held
         ren_q   <= issue_now & ar_held & ~err;
         err_ack <= issue_now & err;              // rejected, skip the bus
      end
   end

   // counts from acceptance until the response goes out
   always_ff @(posedge axi) begin
      if (!rst_n) begin
         cnt <= 6'd0;
      end else if (!busy || resp_out) begin
         cnt <= 6'd0;
      end else begin
         cnt <= cnt + 6'd1;
      end
   end

   assign tmo = (cnt == 6'(`ACK_TIMEOUT));

   always_comb begin
      bus_req.addr  = cur.addr;
      bus_req.wdata = wdata_q;
      bus_req.wen   = wen_q;
      bus_req.ren   = ren_q;
   end

   //////////////////////////////
   // responses
   //////////////////////////////

   assign rsp_due = busy & ~resp_out & (bus_rsp.ack | err_ack | tmo);
   assign fail    = err | tmo;

   always_ff @(posedge axi) begin
      if (!rst_n) begin
         b_valid <= 1'b0;
         r_valid <= 1'b0;
      end else if (rsp_due) begin
         b_valid <= aw_held;
         r_valid <= ar_held;
      end else begin
         if (b_valid && b_ready) b_valid <= 1'b0;
         if (r_valid && r_ready) r_valid <= 1'b0;
      end
   end

   // payload loads once, then stays put under back-pressure
   always_ff @(posedge axi) begin
      if (rsp_due) begin
         b.id   <= aw_req.id;
         b.resp <= fail ? resp_slverr : resp_okay;
         r.id   <= ar_req.id;
         r.data <= fail ? '0 : bus_rsp.rdata;   // no stale data on errors
         r.resp <= fail ? resp_slverr : resp_okay;
         r.last <= 1'b1;                        // single beat
      end
   end

   // frees the holder on the response transfer
   assign aw_done = b_valid & b_ready;
   assign ar_done = r_valid & r_ready;

endmodule

//--- hdl/sys_reg_bank.sv
`timescale 1ns/1ns
//////////////////////////////
// eight 32-bit read/write registers on the system bus, acked a cycle later
//////////////////////////////
`include "sys_bus_consts.svh"

module sys_reg_bank (
   input  logic                  axi,
   input  logic                  rst_n,
   input  sys_bus_pkg::sys_req_t bus_req,
   output sys_bus_pkg::sys_rsp_t bus_rsp
);

   localparam int IDX_W = $clog2(`REG_COUNT);
   localparam logic [`AXI_AW-1:0] BASE = `REG_BASE;

   logic [`AXI_DW-1:0] regs [`REG_COUNT];
   logic [IDX_W-1:0]   idx;
   logic               hit;
   logic               ack_q;
   logic [`AXI_DW-1:0] rdata_q;

   //////////////////////////////
   // address decode
   //////////////////////////////

   // word index inside the window
   assign idx = bus_req.addr[IDX_W+1:2];

   // upper bits must match the base, byte offset ignored
   assign hit = (bus_req.addr[`AXI_AW-1:IDX_W+2] == BASE[`AXI_AW-1:IDX_W+2]);

   //////////////////////////////
   // register file
   //////////////////////////////

   always_ff @(posedge axi) begin
      if (!rst_n) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (bus_req.wen && hit) begin
         regs[idx] <= bus_req.wdata;   // full word, no byte strobes
      end
   end

   //////////////////////////////
   // ack and read data
   //////////////////////////////

   // unmapped strobes never ack, bridge times them out
   always_ff @(posedge axi) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= (bus_req.wen | bus_req.ren) & hit;
      end
   end

   // sampled on the read strobe, valid alongside ack
   always_ff @(posedge axi) begin
      if (bus_req.ren && hit) begin
         rdata_q <= regs[idx];
      end
   end

   always_comb begin
      bus_rsp.rdata = rdata_q;
      bus_rsp.ack   = ack_q;
   end

endmodule

//--- hdl/axi_sys_top.sv
`timescale 1ns/1ns
//////////////////////////////
// axi slave with register bank: address holders, bridge and bus slave
//////////////////////////////

module axi_sys_top (
   input  logic                 axi,
   input  logic                 rst_n,
   // write address
   input  logic                 aw_valid,
   output logic                 aw_ready,
   input  sys_bus_pkg::axi_aw_t aw,
   // write data
   input  logic                 w_valid,
   output logic                 w_ready,
   input  sys_bus_pkg::axi_w_t  w,
   // write response
   output logic                 b_valid,
   input  logic                 b_ready,
   output sys_bus_pkg::axi_b_t  b,
   // read address
   input  logic                 ar_valid,
   output logic                 ar_ready,
   input  sys_bus_pkg::axi_ar_t ar,
   // read data
   output logic                 r_valid,
   input  logic                 r_ready,
   output sys_bus_pkg::axi_r_t  r
);
   import sys_bus_pkg::*;

   logic     aw_held;
   logic     ar_held;
   logic     aw_ok;
   logic     ar_ok;
   logic     aw_done;
   logic     ar_done;
   axi_aw_t  aw_req;
   axi_ar_t  ar_req;
   sys_req_t bus_req;
   sys_rsp_t bus_rsp;

   //////////////////////////////
   // input side
   //////////////////////////////

   axi_req_hold #(.payload_t(axi_aw_t)) i_aw_hold (
      .axi       (axi),
      .rst_n     (rst_n),
      .in_valid  (aw_valid),
      .in_ready  (aw_ready),
      .in_data   (aw),
      .accept_ok (aw_ok),
      .done      (aw_done),
      .held      (aw_held),
      .held_data (aw_req)
   );

   axi_req_hold #(.payload_t(axi_ar_t)) i_ar_hold (
      .axi       (axi),
      .rst_n     (rst_n),
      .in_valid  (ar_valid),
      .in_ready  (ar_ready),
      .in_data   (ar),
      .accept_ok (ar_ok),
      .done      (ar_done),
      .held      (ar_held),
      .held_data (ar_req)
   );

   //////////////////////////////
   // bridge and bank
   //////////////////////////////

   axi_sys_bridge i_bridge (
      .axi      (axi),
      .rst_n    (rst_n),
      .aw_held  (aw_held),
      .aw_req   (aw_req),
      .ar_held  (ar_held),
      .ar_req   (ar_req),
      .aw_ok    (aw_ok),
      .ar_ok    (ar_ok),
      .aw_done  (aw_done),
      .ar_done  (ar_done),
      .aw_valid (aw_valid),   // write priority
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .w        (w),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .b        (b),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .r        (r),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp)
   );

   sys_reg_bank i_regs (
      .axi     (axi),
      .rst_n   (rst_n),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

endmodule

//--- verification/axi_sys_chk.sv
`timescale 1ns/1ns
//////////////////////////////
// protocol assertions for the axi register slave
// bound onto its top level by the testbench
//////////////////////////////

module axi_sys_chk (
   input logic                axi,
   input logic                rst_n,
   input logic                aw_valid,
   input logic                aw_ready,
   input logic                ar_ready,
   input logic                w_ready,
   input logic                b_valid,
   input logic                b_ready,
   input sys_bus_pkg::axi_b_t b,
   input logic                r_valid,
   input logic                r_ready,
   input sys_bus_pkg::axi_r_t r
);

   int unsigned fail_cnt = 0;   // assertion failures so far

   //////////////////////////////
   // back-pressure
   //////////////////////////////

   // write response frozen until taken
   b_hold: assert property (@(posedge axi) disable iff (!rst_n)
         b_valid && !b_ready |=> b_valid && $stable(b))
      else begin
         $error("write response dropped or changed before b_ready");
         fail_cnt++;
      end

   r_hold: assert property (@(posedge axi) disable iff (!rst_n)
         r_valid && !r_ready |=> r_valid && $stable(r))
      else begin
         $error("read response dropped or changed before r_ready");
         fail_cnt++;
      end

   // access still busy while its answer waits
   no_accept: assert property (@(posedge axi) disable iff (!rst_n)
         (b_valid || r_valid) |-> !aw_ready && !ar_ready)
      else begin
         $error("address channel ready while a response is pending");
         fail_cnt++;
      end

   //////////////////////////////
   // reset and single access
   //////////////////////////////

   // one cycle after any reset edge
   reset_lvl: assert property (@(posedge axi)
         !rst_n |=> aw_ready && (ar_ready || aw_valid) && !b_valid && !r_valid && !w_ready)
      else begin
         $error("ready or valid levels wrong after reset");
         fail_cnt++;
      end

   one_rsp: assert property (@(posedge axi) disable iff (!rst_n) b_valid |-> !r_valid)
      else begin
         $error("write and read responses out together");
         fail_cnt++;
      end

endmodule

//--- verification/axi_sys_tb.sv
`timescale 1ns/1ns
//////////////////////////////
// single beat accesses of the axi register slave checked against a register model
// protocol rules live in the bound checker
//////////////////////////////
`include "sys_bus_consts.svh"

module axi_sys_tb;
   import sys_bus_pkg::*;

   localparam int WAIT_MAX = 100;   // cycles per handshake
   localparam int OUTSIDE  = 64;    // slot past the bank window

   logic        axi;
   logic        rst_n;
   logic        aw_valid;
   logic        aw_ready;
   axi_aw_t     aw;
   logic        w_valid;
   logic        w_ready;
   axi_w_t      w;
   logic        b_valid;
   logic        b_ready;
   axi_b_t      b;
   logic        ar_valid;
   logic        ar_ready;
   axi_ar_t     ar;
   logic        r_valid;
   logic        r_ready;
   axi_r_t      r;
   integer      seed;
   int          err_cnt;
   int          tmo_cnt;
   int          checks;
   logic [31:0] model [`REG_COUNT];   // expected register contents
   time         b_seen_at;
   time         r_seen_at;

   axi_sys_top i_dut (.*);

   bind axi_sys_top axi_sys_chk i_chk (.*);

   always #10 axi = ~axi;   // 20 ns period

   task automatic report_and_finish();
      int chk_cnt;
      chk_cnt = int'(i_dut.i_chk.fail_cnt);
      $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
               checks, err_cnt, tmo_cnt, chk_cnt);
      if (err_cnt == 0 && tmo_cnt == 0 && chk_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      tmo_cnt++;
      $display("timeout at %0t: %s did not arrive within %0d cycles", $time, what, WAIT_MAX);
      report_and_finish();
   endtask

   task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         err_cnt++;
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   //////////////////////////////
   // axi master
   //////////////////////////////

   // slots past REG_COUNT fall outside the bank
   task automatic write_reg(input int slot, input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] exp_resp, input int exp_lat, input int hold);
      logic [7:0]  id;
      logic [31:0] data;
      axi_b_t      got;
      int          n;
      id   = 8'($random(seed));
      data = $random(seed);
      @(negedge axi);
      aw_valid = 1'b1;
      aw       = '{id: id, addr: `REG_BASE + 32'(slot) * 4, len: len, size: size};
      w_valid  = 1'b1;                    // data offered with the address
      w        = '{data: data, last: 1'b1};
      n = 0;
      #1;
      while (!aw_ready) begin
         if (n == WAIT_MAX) give_up("aw_ready");
         @(negedge axi);
         #1;
         n++;
      end
      @(negedge axi);
      aw_valid = 1'b0;
      n = 0;
      #1;
      while (!w_ready) begin
         if (n == WAIT_MAX) give_up("w_ready");
         @(negedge axi);
         #1;
         n++;
      end
      @(negedge axi);
      w_valid = 1'b0;
      n = 0;                              // counts from the w transfer
      while (!b_valid) begin
         if (n == WAIT_MAX) give_up("write response");
         @(negedge axi);
         n++;
      end
      got       = b;
      b_seen_at = $time;
      expect_eq("b.id", 32'(got.id), 32'(id));
      expect_eq("b.resp", 32'(got.resp), 32'(exp_resp));
      expect_eq("write latency", n, exp_lat);
      if (exp_resp == resp_okay) model[slot[2:0]] = data;
      repeat (hold) @(negedge axi);      // back-pressure
      b_ready = 1'b1;
      @(negedge axi);
      b_ready = 1'b0;
   endtask

   task automatic read_reg(input int slot, input logic [7:0] len, input logic [2:0] size,
                           input logic [1:0] exp_resp, input int exp_lat, input int hold);
      logic [7:0]  id;
      logic [31:0] exp_data;
      axi_r_t      got;
      int          n;
      id = 8'($random(seed));
      @(negedge axi);
      ar_valid = 1'b1;
      ar       = '{id: id, addr: `REG_BASE + 32'(slot) * 4, len: len, size: size};
      n = 0;
      #1;
      while (!ar_ready) begin
         if (n == WAIT_MAX) give_up("ar_ready");
         @(negedge axi);
         #1;
         n++;
      end
      @(negedge axi);
      ar_valid = 1'b0;
      n = 0;                              // counts from the ar transfer
      while (!r_valid) begin
         if (n == WAIT_MAX) give_up("read response");
         @(negedge axi);
         n++;
      end
      got       = r;
      r_seen_at = $time;
      exp_data  = (exp_resp == resp_okay) ? model[slot[2:0]] : 32'h0;   // errors read zero
      expect_eq("r.id", 32'(got.id), 32'(id));
      expect_eq("r.data", got.data, exp_data);
      expect_eq("r.resp", 32'(got.resp), 32'(exp_resp));
      expect_eq("r.last", 32'(got.last), 32'd1);
      expect_eq("read latency", n, exp_lat);
      repeat (hold) @(negedge axi);
      r_ready = 1'b1;
      @(negedge axi);
      r_ready = 1'b0;
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////

   initial begin
      int hold_b;
      int hold_r;
      seed     = 56;
      err_cnt  = 0;
      tmo_cnt  = 0;
      checks   = 0;
      axi      = 1'b0;
      rst_n    = 1'b0;
      aw_valid = 1'b0;
      aw       = '0;
      w_valid  = 1'b0;
      w        = '0;
      b_ready  = 1'b0;
      ar_valid = 1'b0;
      ar       = '0;
      r_ready  = 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
      repeat (8) @(negedge axi);
      rst_n = 1'b1;
      // bank is all zero out of reset
      for (int i = 0; i < `REG_COUNT; i++) read_reg(i, 8'd0, 3'd2, resp_okay, 3, 0);
      // random fill and read back
      for (int i = 0; i < `REG_COUNT; i++) write_reg(i, 8'd0, 3'd2, resp_okay, 3, 0);
      for (int i = 0; i < `REG_COUNT; i++) read_reg(i, 8'd0, 3'd2, resp_okay, 3, 0);
      write_reg(3, 8'd0, 3'd1, resp_okay, 3, 0);   // 2 byte size is legal too
      read_reg(3, 8'd0, 3'd1, resp_okay, 3, 0);
      // bursts and byte size rejected without a bus access
      write_reg(2, 8'd3, 3'd2, resp_slverr, 2, 0);
      write_reg(2, 8'd0, 3'd0, resp_slverr, 2, 0);
      read_reg(2, 8'd1, 3'd2, resp_slverr, 2, 0);
      read_reg(2, 8'd0, 3'd0, resp_slverr, 2, 0);
      read_reg(2, 8'd0, 3'd2, resp_okay, 3, 0);    // value untouched
      // no ack outside the window
      read_reg(OUTSIDE, 8'd0, 3'd2, resp_slverr, `ACK_TIMEOUT + 1, 0);
      write_reg(OUTSIDE, 8'd0, 3'd2, resp_slverr, `ACK_TIMEOUT, 0);   // timer starts at aw
      read_reg(5, 8'd0, 3'd2, resp_okay, 3, 0);
      // write and read offered together under response back-pressure
      for (int k = 0; k < 4; k++) begin
         hold_b = 1 + ($random(seed) & 7);
         hold_r = 1 + ($random(seed) & 7);
         fork
            write_reg(k, 8'd0, 3'd2, resp_okay, 3, hold_b);
            read_reg(k, 8'd0, 3'd2, resp_okay, 3, hold_r);
         join
         expect_eq("write answered first", 32'(b_seen_at < r_seen_at), 32'd1);
      end
      report_and_finish();
   end

endmodule

//--- sources.f
+incdir+hdl
hdl/sys_bus_pkg.sv
hdl/axi_req_hold.sv
hdl/axi_sys_bridge.sv
hdl/sys_reg_bank.sv
hdl/axi_sys_top.sv
verification/axi_sys_chk.sv
verification/axi_sys_tb.sv

//--- Makefile
# Verilator build and run of the axi register slave testbench

VERILATOR ?= verilator
TOP       ?= axi_sys_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ns
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
